//--- exec_unit.f
+incdir+.
exec_pkg.sv
cmd_fifo.sv
apb_cmd_port.sv
alu_core.sv
exec_unit.sv
tb_exec_unit.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/100ps -f exec_unit.f \
    --top-module tb_exec_unit -o tb_exec_unit > build.log 2>&1 &&
    ./obj_dir/tb_exec_unit > sim.log 2>&1
grep -qx "ALL CHECKS PASSED" sim.log && echo "PASS" ||
    { echo "FAIL, see build.log and sim.log"; exit 1; }

//--- tb_exec_unit.sv
`include "exec_config.svh"

module tb_exec_unit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH      = `EXEC_FIFO_DEPTH;
    localparam int POLL_LIMIT = 40;     // status polls per wait

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`EXEC_APB_AW-1:0] paddr;
    logic [`EXEC_XLEN-1:0]   pwdata;
    logic [`EXEC_XLEN-1:0]   prdata;
    logic                    pready;
    logic                    pslverr;

    int n_checks;
    int n_errors;

    // reference model state
    logic [31:0] m_result;
    logic [31:0] m_hi;
    logic [31:0] m_lo;
    logic        m_ovf;
    logic [7:0]  m_done;

    exec_unit dut0 (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #2 clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // setup phase, then access phase sampled mid-cycle
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #0.5;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #0.5;
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        check("pready", 32'(pready), 32'd1);    // zero-wait slave
        @(posedge clk);
        #0.5;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check("pslverr", 32'(err), 32'd0);
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_read(addr, data, err);
        check("pslverr", 32'(err), 32'd0);
    endtask

    task automatic wait_done(input logic [7:0] target);
        logic [31:0] st;
        logic        err;
        logic        hit;
        hit = 1'b0;
        for (int polls = 0; polls < POLL_LIMIT && !hit; polls++) begin
            apb_read(`EXEC_REG_STATUS, st, err);
            hit = (st[15:8] === target);
        end
        if (!hit) begin
            n_errors++;
            $display("timeout: done count did not reach %0d", target);
        end
    endtask

    // length of the leading run of bitval bits
    function automatic logic [31:0] count_lead(input logic [31:0] x, input logic bitval);
        int n;
        n = 0;
        for (int i = 31; i >= 0; i--) begin
            if (x[i] != bitval) begin
                break;
            end
            n++;
        end
        return 32'(n);
    endfunction

    task automatic model_exec(input exec_pkg::alu_op_e op, input logic [31:0] a,
                              input logic [31:0] b);
        longint      sa;
        longint      sb;
        longint      wide;
        logic [63:0] prod;
        logic [31:0] res;
        logic        wr_res;
        logic        ovf;
        sa     = longint'($signed(a));
        sb     = longint'($signed(b));
        res    = '0;
        wr_res = 1'b1;
        ovf    = 1'b0;
        case (op)
            exec_pkg::OP_OR:    res = a | b;
            exec_pkg::OP_AND:   res = a & b;
            exec_pkg::OP_NOR:   res = ~(a | b);
            exec_pkg::OP_XOR:   res = a ^ b;
            exec_pkg::OP_SLL:   res = b << a[4:0];
            exec_pkg::OP_SRL:   res = b >> a[4:0];
            exec_pkg::OP_SRA:   res = $signed(b) >>> a[4:0];
            exec_pkg::OP_ADD, exec_pkg::OP_SUB: begin
                wide = (op == exec_pkg::OP_ADD) ? sa + sb : sa - sb;
                res  = wide[31:0];
                ovf  = wide[32] ^ wide[31];     // true sum outside signed range
            end
            exec_pkg::OP_ADDU:  res = a + b;
            exec_pkg::OP_SUBU:  res = a - b;
            exec_pkg::OP_SLT:   res = (sa < sb) ? 32'd1 : 32'd0;
            exec_pkg::OP_SLTU:  res = (a < b) ? 32'd1 : 32'd0;
            exec_pkg::OP_CLZ:   res = count_lead(a, 1'b0);
            exec_pkg::OP_CLO:   res = count_lead(a, 1'b1);
            exec_pkg::OP_MUL: begin
                wide = sa * sb;
                res  = wide[31:0];
            end
            exec_pkg::OP_MULT, exec_pkg::OP_MULTU: begin
                if (op == exec_pkg::OP_MULT) begin
                    wide = sa * sb;
                    prod = wide;
                end else begin
                    prod = {32'h0, a} * {32'h0, b};
                end
                m_hi   = prod[63:32];
                m_lo   = prod[31:0];
                wr_res = 1'b0;
            end
            exec_pkg::OP_MFHI:  res = m_hi;
            exec_pkg::OP_MFLO:  res = m_lo;
            exec_pkg::OP_MTHI: begin
                m_hi   = a;
                wr_res = 1'b0;
            end
            default: begin      // MTLO
                m_lo   = a;
                wr_res = 1'b0;
            end
        endcase
        if (wr_res && !ovf) begin
            m_result = res;
        end
        m_ovf  = ovf;
        m_done = m_done + 8'd1;
    endtask

    task automatic check_state();
        logic [31:0] rd;
        reg_read(`EXEC_REG_RESULT, rd);
        check("result", rd, m_result);
        reg_read(`EXEC_REG_STATUS, rd);
        check("status.ovf", 32'(rd[2]), 32'(m_ovf));
        reg_read(`EXEC_REG_HI, rd);
        check("hi", rd, m_hi);
        reg_read(`EXEC_REG_LO, rd);
        check("lo", rd, m_lo);
    endtask

    task automatic exec_and_check(input exec_pkg::alu_op_e op, input logic [31:0] a,
                                  input logic [31:0] b);
        reg_write(`EXEC_REG_OPA, a);
        reg_write(`EXEC_REG_OPB, b);
        reg_write(`EXEC_REG_CMD, 32'(op));
        model_exec(op, a, b);
        wait_done(m_done);
        check_state();
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s finished, %0d errors", name, n_errors - errors_before);
    endtask

    task automatic test_logic_shift();
        int e0;
        e0 = n_errors;
        for (int rep = 0; rep < 3; rep++) begin
            for (int k = 0; k <= 6; k++) begin      // OR up to SRA
                exec_and_check(exec_pkg::alu_op_e'(k), $urandom(), $urandom());
            end
        end
        exec_and_check(exec_pkg::OP_SRA, 32'd7, $urandom() | 32'h8000_0000);
        exec_and_check(exec_pkg::OP_SRA, 32'd31, 32'h8000_0001);
        report_test("logic_shift", e0);
    endtask

    task automatic test_arith_count();
        int e0;
        e0 = n_errors;
        exec_and_check(exec_pkg::OP_ADDU, $urandom(), $urandom());
        exec_and_check(exec_pkg::OP_SUBU, $urandom(), $urandom());
        exec_and_check(exec_pkg::OP_ADD, 32'd100, 32'hffff_ffe2);
        exec_and_check(exec_pkg::OP_SUB, 32'hffff_fffb, 32'd20);
        exec_and_check(exec_pkg::OP_SLT, 32'hffff_ffff, 32'd1);
        exec_and_check(exec_pkg::OP_SLT, 32'd1, 32'hffff_ffff);
        exec_and_check(exec_pkg::OP_SLT, 32'h8000_0000, 32'h7fff_ffff);
        exec_and_check(exec_pkg::OP_SLTU, 32'd1, 32'hffff_ffff);
        exec_and_check(exec_pkg::OP_SLTU, 32'hffff_ffff, 32'd1);
        exec_and_check(exec_pkg::OP_CLZ, $urandom() >> ($urandom() % 32), 32'd0);
        exec_and_check(exec_pkg::OP_CLZ, 32'h0, 32'd0);
        exec_and_check(exec_pkg::OP_CLO, ~($urandom() >> 5), 32'd0);
        exec_and_check(exec_pkg::OP_CLO, 32'hffff_ffff, 32'd0);
        report_test("arith_count", e0);
    endtask

    task automatic test_overflow();
        int          e0;
        logic [31:0] rd;
        e0 = n_errors;
        exec_and_check(exec_pkg::OP_ADDU, 32'h1234_0000, 32'h0000_5678);
        exec_and_check(exec_pkg::OP_ADD, 32'h7fff_ffff, 32'd1);
        reg_read(`EXEC_REG_RESULT, rd);
        check("result held", rd, 32'h1234_5678);
        exec_and_check(exec_pkg::OP_SUB, 32'h8000_0000, 32'd1);
        reg_read(`EXEC_REG_STATUS, rd);
        check("status.ovf", 32'(rd[2]), 32'd1);
        exec_and_check(exec_pkg::OP_ADDU, 32'h7fff_ffff, 32'd1);   // clears the flag
        report_test("overflow", e0);
    endtask

    task automatic test_hilo();
        int e0;
        e0 = n_errors;
        exec_and_check(exec_pkg::OP_MULT, 32'hffff_fff9, 32'd123456);
        exec_and_check(exec_pkg::OP_MULT, 32'h8000_0000, 32'h7fff_ffff);
        exec_and_check(exec_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_fffe);
        exec_and_check(exec_pkg::OP_MULTU, $urandom() | 32'h8000_0000, $urandom());
        exec_and_check(exec_pkg::OP_MUL, 32'hffff_fffd, 32'd5);
        exec_and_check(exec_pkg::OP_MTHI, 32'hdead_beef, 32'd0);
        exec_and_check(exec_pkg::OP_MTLO, 32'h0bad_f00d, 32'd0);
        exec_and_check(exec_pkg::OP_MFHI, 32'd0, 32'd0);
        exec_and_check(exec_pkg::OP_MFLO, 32'd0, 32'd0);
        report_test("hilo", e0);
    endtask

    task automatic test_queue_errors();
        int                e0;
        logic [31:0]       rd;
        logic [31:0]       a;
        logic              err;
        logic [7:0]        done0;
        exec_pkg::alu_op_e op;
        e0    = n_errors;
        done0 = m_done;
        reg_write(`EXEC_REG_CTRL, 32'd0);      // pause the ALU
        reg_write(`EXEC_REG_OPB, 32'h0000_00ff);
        for (int k = 0; k < DEPTH; k++) begin
            a  = $urandom();
            op = (k == DEPTH - 1) ? exec_pkg::OP_SUBU : exec_pkg::OP_XOR;
            reg_write(`EXEC_REG_OPA, a);
            reg_write(`EXEC_REG_CMD, 32'(op));
            model_exec(op, a, 32'h0000_00ff);
        end
        reg_read(`EXEC_REG_STATUS, rd);
        check("status.full", 32'(rd[1]), 32'd1);
        check("status.done", 32'(rd[15:8]), 32'(done0));
        apb_write(`EXEC_REG_CMD, 32'(exec_pkg::OP_OR), err);
        check("pslverr on full", 32'(err), 32'd1);
        reg_write(`EXEC_REG_CTRL, 32'd1);
        wait_done(m_done);
        reg_read(`EXEC_REG_STATUS, rd);
        check("status.done", 32'(rd[15:8]), 32'(done0) + 32'(DEPTH));
        check("status.empty", 32'(rd[0]), 32'd1);
        check_state();
        apb_write(`EXEC_REG_CMD, 32'd22, err);      // first code past MTLO
        check("pslverr bad opcode", 32'(err), 32'd1);
        apb_write(`EXEC_REG_STATUS, 32'hffff_ffff, err);
        check("pslverr status write", 32'(err), 32'd1);
        apb_write(8'h20, 32'h0, err);
        check("pslverr unmapped", 32'(err), 32'd1);
        reg_read(`EXEC_REG_STATUS, rd);
        check("status.done", 32'(rd[15:8]), 32'(m_done));
        check("status.empty", 32'(rd[0]), 32'd1);
        report_test("queue_errors", e0);
    endtask

    initial begin
        logic [31:0] rd;
        rst_n    = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        n_checks = 0;
        n_errors = 0;
        m_result = '0;
        m_hi     = '0;
        m_lo     = '0;
        m_ovf    = 1'b0;
        m_done   = '0;
        void'($urandom(32'hdfdd_9273));
        repeat (5) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        reg_read(`EXEC_REG_STATUS, rd);
        check("status after reset", rd, 32'h0000_0001);
        test_logic_shift();
        test_arith_count();
        test_overflow();
        test_hilo();
        test_queue_errors();
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- exec_unit.sv
`include "exec_config.svh"

module exec_unit (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  logic [`EXEC_APB_AW-1:0]  paddr_i,
    input  logic [`EXEC_XLEN-1:0]    pwdata_i,
    output logic [`EXEC_XLEN-1:0]    prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o
);

    logic                   push;
    exec_pkg::cmd_t         push_data;
    logic                   pop;
    exec_pkg::cmd_t         head;
    logic                   fifo_full;
    logic                   fifo_empty;
    logic                   run;
    logic [`EXEC_XLEN-1:0]  result;
    exec_pkg::hilo_u        hilo;
    logic                   ovf;
    logic [7:0]             done_cnt;

    // producer, apb side
    apb_cmd_port u_port (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .fifo_full_i  (fifo_full),
        .fifo_empty_i (fifo_empty),
        .result_i     (result),
        .hilo_i       (hilo),
        .ovf_i        (ovf),
        .done_cnt_i   (done_cnt),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .push_o       (push),
        .push_data_o  (push_data),
        .run_o        (run)
    );

    cmd_fifo #(
        .DEPTH   (`EXEC_FIFO_DEPTH),
        .entry_t (exec_pkg::cmd_t)
    ) u_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_o      (head),
        .empty_o     (fifo_empty),
        .full_o      (fifo_full)
    );

    // consumer
    alu_core u_alu (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .run_i        (run),
        .fifo_empty_i (fifo_empty),
        .cmd_i        (head),
        .pop_o        (pop),
        .result_o     (result),
        .hilo_o       (hilo),
        .ovf_o        (ovf),
        .done_cnt_o   (done_cnt)
    );

endmodule

//--- alu_core.sv
`include "exec_config.svh"

module alu_core (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   run_i,
    input  logic                   fifo_empty_i,
    input  exec_pkg::cmd_t         cmd_i,
    output logic                   pop_o,
    output logic [`EXEC_XLEN-1:0]  result_o,
    output exec_pkg::hilo_u        hilo_o,
    output logic                   ovf_o,
    output logic [7:0]             done_cnt_o
);

    localparam int XLEN  = `EXEC_XLEN;
    localparam int MSB   = XLEN - 1;
    localparam int CNT_W = $clog2(XLEN) + 1;   // holds 0..XLEN

    exec_pkg::alu_op_e   op;
    logic [XLEN-1:0]     a;
    logic [XLEN-1:0]     b;
    logic                pop;
    logic                is_sub;
    logic [XLEN-1:0]     b_mux;
    logic [XLEN-1:0]     sum;
    logic                add_ovf;
    logic                less;
    logic                mul_signed;
    logic [XLEN-1:0]     mag_a;
    logic [XLEN-1:0]     mag_b;
    logic [2*XLEN-1:0]   prod_mag;
    logic [2*XLEN-1:0]   prod;
    logic                ovf_op;
    logic                hold_result;
    logic [XLEN-1:0]     alu_res;
    logic [XLEN-1:0]     result_q;
    exec_pkg::hilo_u     hilo_q;
    logic                ovf_q;
    logic [7:0]          done_cnt_q;

    // leading zeros, XLEN for an all-zero word
    function automatic logic [CNT_W-1:0] lead_zeros(input logic [XLEN-1:0] x);
        logic [CNT_W-1:0] n;
        logic             hit;
        n   = '0;
        hit = 1'b0;
        for (int i = MSB; i >= 0; i--) begin
            if (x[i]) begin
                hit = 1'b1;
            end else if (!hit) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign op  = cmd_i.op;
    assign a   = cmd_i.opa;
    assign b   = cmd_i.opb;
    assign pop = run_i & !fifo_empty_i;

    // shared adder, subtract by two's complement
    assign is_sub = (op == exec_pkg::OP_SUB) || (op == exec_pkg::OP_SUBU) ||
                    (op == exec_pkg::OP_SLT);
    assign b_mux  = is_sub ? (~b + 1'b1) : b;
    assign sum    = a + b_mux;

    // signed overflow from operand and sum signs
    assign add_ovf = is_sub ? ((a[MSB] != b[MSB]) && (sum[MSB] != a[MSB]))
                            : ((a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]));

    // signed: differing signs decide, else sign of a-b
    assign less = (op == exec_pkg::OP_SLT) ?
                  ((a[MSB] & !b[MSB]) | (!(a[MSB] ^ b[MSB]) & sum[MSB])) :
                  (a < b);

    // multiply magnitudes, fix the sign afterwards
    assign mul_signed = (op == exec_pkg::OP_MUL) || (op == exec_pkg::OP_MULT);
    assign mag_a      = (mul_signed && a[MSB]) ? (~a + 1'b1) : a;
    assign mag_b      = (mul_signed && b[MSB]) ? (~b + 1'b1) : b;
    assign prod_mag   = {{XLEN{1'b0}}, mag_a} * {{XLEN{1'b0}}, mag_b};
    assign prod       = (mul_signed && (a[MSB] ^ b[MSB])) ? (~prod_mag + 1'b1) : prod_mag;

    always_comb begin
        case (op)
            exec_pkg::OP_OR:    alu_res = a | b;
            exec_pkg::OP_AND:   alu_res = a & b;
            exec_pkg::OP_NOR:   alu_res = ~(a | b);
            exec_pkg::OP_XOR:   alu_res = a ^ b;
            exec_pkg::OP_SLL:   alu_res = b << a[4:0];     // amount from opa
            exec_pkg::OP_SRL:   alu_res = b >> a[4:0];
            exec_pkg::OP_SRA:   alu_res = $signed(b) >>> a[4:0];
            exec_pkg::OP_ADD,
            exec_pkg::OP_ADDU,
            exec_pkg::OP_SUB,
            exec_pkg::OP_SUBU:  alu_res = sum;
            exec_pkg::OP_SLT,
            exec_pkg::OP_SLTU:  alu_res = {{(XLEN-1){1'b0}}, less};
            exec_pkg::OP_CLZ:   alu_res = XLEN'(lead_zeros(a));
            exec_pkg::OP_CLO:   alu_res = XLEN'(lead_zeros(~a));
            exec_pkg::OP_MUL:   alu_res = prod[XLEN-1:0];    // low word only
            exec_pkg::OP_MFHI:  alu_res = hilo_q.half.hi;
            exec_pkg::OP_MFLO:  alu_res = hilo_q.half.lo;
            default:            alu_res = '0;                // hi/lo writers
        endcase
    end

    assign ovf_op      = (op == exec_pkg::OP_ADD) || (op == exec_pkg::OP_SUB);
    assign hold_result = (ovf_op && add_ovf) ||
                         (op == exec_pkg::OP_MULT) || (op == exec_pkg::OP_MULTU) ||
                         (op == exec_pkg::OP_MTHI) || (op == exec_pkg::OP_MTLO);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_q   <= '0;
            hilo_q     <= '0;
            ovf_q      <= 1'b0;
            done_cnt_q <= '0;
        end else if (pop) begin
            if (!hold_result) begin
                result_q <= alu_res;
            end
            case (op)
                exec_pkg::OP_MULT,
                exec_pkg::OP_MULTU: hilo_q.prod    <= prod;
                exec_pkg::OP_MTHI:  hilo_q.half.hi <= a;
                exec_pkg::OP_MTLO:  hilo_q.half.lo <= a;
                default: begin
                end
            endcase
            ovf_q      <= ovf_op & add_ovf;     // any other op clears it
            done_cnt_q <= done_cnt_q + 8'd1;    // wraps
        end
    end

    assign pop_o      = pop;
    assign result_o   = result_q;
    assign hilo_o     = hilo_q;
    assign ovf_o      = ovf_q;
    assign done_cnt_o = done_cnt_q;

endmodule

//--- apb_cmd_port.sv
`include "exec_config.svh"

module apb_cmd_port (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  logic [`EXEC_APB_AW-1:0]  paddr_i,
    input  logic [`EXEC_XLEN-1:0]    pwdata_i,
    input  logic                     fifo_full_i,
    input  logic                     fifo_empty_i,
    input  logic [`EXEC_XLEN-1:0]    result_i,
    input  exec_pkg::hilo_u          hilo_i,
    input  logic                     ovf_i,
    input  logic [7:0]               done_cnt_i,
    output logic [`EXEC_XLEN-1:0]    prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,
    output logic                     push_o,
    output exec_pkg::cmd_t           push_data_o,
    output logic                     run_o
);

    logic                  access;      // apb access phase
    logic                  mapped;
    logic                  read_only;
    logic                  wr_opa;
    logic                  wr_opb;
    logic                  wr_cmd;
    logic                  wr_ctrl;
    logic                  op_legal;
    logic                  cmd_err;
    logic [`EXEC_XLEN-1:0] opa_q;
    logic [`EXEC_XLEN-1:0] opb_q;
    logic                  run_q;
    logic [`EXEC_XLEN-1:0] status;
    logic [`EXEC_XLEN-1:0] rdata;

    assign access = psel_i & penable_i;

    assign wr_opa  = access & pwrite_i & (paddr_i == `EXEC_REG_OPA);
    assign wr_opb  = access & pwrite_i & (paddr_i == `EXEC_REG_OPB);
    assign wr_cmd  = access & pwrite_i & (paddr_i == `EXEC_REG_CMD);
    assign wr_ctrl = access & pwrite_i & (paddr_i == `EXEC_REG_CTRL);

    // opcode from bits 4..0 only
    assign op_legal = (pwdata_i[4:0] <= exec_pkg::OP_MTLO);
    assign cmd_err  = wr_cmd & (!op_legal | fifo_full_i);

    assign status = {16'h0000, done_cnt_i, 5'b00000, ovf_i, fifo_full_i, fifo_empty_i};

    // address decode and read mux
    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        rdata     = '0;
        case (paddr_i)
            `EXEC_REG_OPA:  rdata = opa_q;
            `EXEC_REG_OPB:  rdata = opb_q;
            `EXEC_REG_CMD:  rdata = '0;     // write only
            `EXEC_REG_RESULT: begin
                rdata     = result_i;
                read_only = 1'b1;
            end
            `EXEC_REG_HI: begin
                rdata     = hilo_i.half.hi;
                read_only = 1'b1;
            end
            `EXEC_REG_LO: begin
                rdata     = hilo_i.half.lo;
                read_only = 1'b1;
            end
            `EXEC_REG_STATUS: begin
                rdata     = status;
                read_only = 1'b1;
            end
            `EXEC_REG_CTRL: rdata = {{(`EXEC_XLEN-1){1'b0}}, run_q};
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            opa_q <= '0;
            opb_q <= '0;
            run_q <= 1'b1;              // consumer runs out of reset
        end else begin
            if (wr_opa) begin
                opa_q <= pwdata_i;
            end
            if (wr_opb) begin
                opb_q <= pwdata_i;
            end
            if (wr_ctrl) begin
                run_q <= pwdata_i[0];
            end
        end
    end

    // queue the command with the operands as they stand now
    assign push_o      = wr_cmd & !cmd_err;
    assign push_data_o = '{op:  exec_pkg::alu_op_e'(pwdata_i[4:0]),
                           opa: opa_q,
                           opb: opb_q};

    assign prdata_o  = (access & !pwrite_i) ? rdata : '0;
    assign pready_o  = 1'b1;            // zero wait
    assign pslverr_o = access & (!mapped | (pwrite_i & read_only) | cmd_err);
    assign run_o     = run_q;

endmodule

//--- cmd_fifo.sv
module cmd_fifo #(
    parameter int  DEPTH   = 4,     // at least 2
    parameter type entry_t = logic
) (
    input  logic   clk_i,
    input  logic   rst_n_i,
    input  logic   push_i,
    input  entry_t push_data_i,
    input  logic   pop_i,
    output entry_t head_o,
    output logic   empty_o,
    output logic   full_o
);

    localparam int PTR_W = $clog2(DEPTH);

    entry_t             mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;      // occupancy 0..DEPTH

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or push+pop
            endcase
        end
    end

    assign head_o  = mem[rd_ptr];   // fall-through head
    assign empty_o = (count == '0);
    assign full_o  = (count == (PTR_W + 1)'(DEPTH));

endmodule

//--- exec_pkg.sv
`include "exec_config.svh"

package exec_pkg;

    // opcodes in command order, anything above OP_MTLO is illegal
    typedef enum logic [4:0] {
        OP_OR,
        OP_AND,
        OP_NOR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MUL,
        OP_MULT,
        OP_MULTU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

    // one queue entry
    typedef struct packed {
        alu_op_e               op;
        logic [`EXEC_XLEN-1:0] opa;
        logic [`EXEC_XLEN-1:0] opb;
    } cmd_t;

    // full product or separate halves
    typedef union packed {
        logic [2*`EXEC_XLEN-1:0] prod;
        struct packed {
            logic [`EXEC_XLEN-1:0] hi;
            logic [`EXEC_XLEN-1:0] lo;
        } half;
    } hilo_u;

endpackage

//--- exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// datapath word
`define EXEC_XLEN         32

// apb address bus, offsets below are sized to it
`define EXEC_APB_AW       8

// command queue entries
`define EXEC_FIFO_DEPTH   4

// register map, byte offsets
`define EXEC_REG_OPA      8'h00
`define EXEC_REG_OPB      8'h04
`define EXEC_REG_CMD      8'h08   // write only
`define EXEC_REG_RESULT   8'h0C
`define EXEC_REG_HI       8'h10
`define EXEC_REG_LO       8'h14
`define EXEC_REG_STATUS   8'h18
`define EXEC_REG_CTRL     8'h1C

`endif
